// ==== all.f ====
common/vmem_pkg.sv
source/mem_controller.sv
source/sram_bank.sv
source/read_return.sv
source/vmem_top.sv
testbench/vmem_checker.sv
testbench/tb_vmem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_vmem
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_vmem.sv ====
`timescale 1ns/1ps

module tb_vmem;

    localparam int LANES      = 8;
    localparam int DATA_DEPTH = 256;
    localparam int TEXT_DEPTH = 512;
    localparam int SEED       = 77943;
    localparam bit WR         = 1'b0;
    localparam bit RD         = 1'b1;

    typedef vmem_pkg::word_t [LANES-1:0] vec_t;

    logic               clk = 1'b0;
    logic               arst_n;
    vmem_pkg::mem_req_t req;
    vec_t               wdata;
    vec_t               inv_l;
    vec_t               inv_u;
    vec_t               rdata;
    string              cur_name;
    int                 n_pass;
    int                 n_fail;
    bit                 table_ready = 1'b0;

    // stimulus table
    bit          op_q[$];
    logic [11:0] addr_q[$];
    logic [2:0]  width_q[$];
    vec_t        wdata_q[$];
    string       name_q[$];

    always #5 clk = ~clk;

    vmem_top #(
        .LANES      (LANES),
        .DATA_DEPTH (DATA_DEPTH),
        .TEXT_DEPTH (TEXT_DEPTH)
    ) UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .wdata  (wdata),
        .inv_l  (inv_l),
        .inv_u  (inv_u),
        .rdata  (rdata)
    );

    vmem_checker #(
        .LANES      (LANES),
        .DATA_DEPTH (DATA_DEPTH),
        .TEXT_DEPTH (TEXT_DEPTH)
    ) u_check (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .wdata  (wdata),
        .inv_l  (inv_l),
        .inv_u  (inv_u),
        .rdata  (rdata),
        .name   (cur_name),
        .n_pass (n_pass),
        .n_fail (n_fail)
    );

    task automatic add_row(input bit op, input logic [11:0] addr, input logic [2:0] width,
                           input string tname);
        vec_t v;
        for (int k = 0; k < LANES; k++) begin
            v[k] = $urandom();
        end
        op_q.push_back(op);
        addr_q.push_back(addr);
        width_q.push_back(width);
        wdata_q.push_back(v);
        name_q.push_back(tname);
    endtask

    task automatic build_table();
        add_row(WR, 12'h010, 3'b111, "full write 010");
        add_row(RD, 12'h010, 3'b000, "full read 010");
        // partial writes over filled rows
        add_row(WR, 12'h020, 3'b000, "fill row 020");
        add_row(WR, 12'h028, 3'b111, "fill row 028");
        add_row(WR, 12'h020, vmem_pkg::W_1, "1 lane at offset 0");
        add_row(WR, 12'h023, vmem_pkg::W_2, "2 lanes at offset 3");
        add_row(WR, 12'h026, vmem_pkg::W_4, "4 lanes at offset 6");
        add_row(RD, 12'h020, 3'b000, "read row 020 off 0");
        add_row(RD, 12'h023, 3'b000, "read row 020 off 3");
        add_row(RD, 12'h026, 3'b000, "read row 020 off 6");
        add_row(RD, 12'h028, 3'b000, "next row intact");
        // instruction region
        add_row(WR, 12'h000, 3'b111, "fill row 000");
        add_row(WR, 12'h805, 3'b111, "text write 805");
        add_row(WR, 12'h9ff, vmem_pkg::W_1, "text write 9ff");
        add_row(RD, 12'h805, 3'b000, "text read 805");
        add_row(RD, 12'h9ff, 3'b000, "text read 9ff");
        add_row(RD, 12'h005, 3'b000, "data 005 untouched");
        add_row(RD, 12'h000, 3'b000, "data 000 untouched");
        // words that share low address bits with a00, a03 and a04
        add_row(WR, 12'h200, 3'b111, "fill row 200");
        add_row(WR, 12'h800, 3'b111, "fill text 800");
        add_row(WR, 12'h803, 3'b111, "fill text 803");
        add_row(WR, 12'h804, 3'b111, "fill text 804");
        // read-only inversion results
        add_row(RD, 12'ha03, 3'b000, "inv_l read");
        add_row(RD, 12'ha04, 3'b000, "inv_u read");
        add_row(WR, 12'ha03, 3'b111, "inv_l write");
        add_row(WR, 12'ha04, 3'b111, "inv_u write");
        add_row(RD, 12'ha03, 3'b000, "inv_l after write");
        add_row(RD, 12'ha04, 3'b000, "inv_u after write");
        // unmapped
        add_row(WR, 12'ha00, 3'b111, "write a00");
        add_row(RD, 12'ha00, 3'b000, "unmapped a00");
        add_row(RD, 12'ha02, 3'b000, "unmapped a02");
        add_row(RD, 12'hfff, 3'b000, "unmapped fff");
        add_row(RD, 12'hc10, 3'b000, "unmapped c10");
        add_row(RD, 12'h200, 3'b000, "data row 200 unchanged");
        add_row(RD, 12'h800, 3'b000, "text 800 unchanged");
        add_row(RD, 12'h803, 3'b000, "text 803 unchanged");
        add_row(RD, 12'h804, 3'b000, "text 804 unchanged");
    endtask

    initial begin
        void'($urandom(SEED));
        req      <= '0;
        wdata    <= '0;
        cur_name <= "";
        arst_n   <= 1'b0;
        for (int k = 0; k < LANES; k++) begin
            inv_l[k] <= $urandom();
            inv_u[k] <= $urandom();
        end
        build_table();
        table_ready = 1'b1;

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // one row per cycle and an idle cycle after each read
        for (int i = 0; i < op_q.size(); i++) begin
            @(posedge clk);
            req      <= '{rd: op_q[i], wr: !op_q[i], addr: addr_q[i], width: width_q[i]};
            wdata    <= wdata_q[i];
            cur_name <= name_q[i];
            if (op_q[i] == RD) begin
                @(posedge clk);
                req <= '0;
            end
        end
        @(posedge clk);
        req <= '0;
        repeat (3) @(posedge clk);

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit;
        wait (table_ready);
        limit = op_q.size() * 2 + 20;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the stimulus loop did not finish", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== testbench/vmem_checker.sv ====
`timescale 1ns/1ps

module vmem_checker #(
    parameter int LANES      = 8,
    parameter int DATA_DEPTH = 256,
    parameter int TEXT_DEPTH = 512
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  vmem_pkg::mem_req_t            req,
    input  vmem_pkg::word_t [LANES-1:0]   wdata,
    input  vmem_pkg::word_t [LANES-1:0]   inv_l,
    input  vmem_pkg::word_t [LANES-1:0]   inv_u,
    input  vmem_pkg::word_t [LANES-1:0]   rdata,
    input  string                         name,
    output int                            n_pass,
    output int                            n_fail
);

    localparam int IDX_W  = $clog2(DATA_DEPTH * LANES);
    localparam int TIDX_W = $clog2(TEXT_DEPTH);

    typedef vmem_pkg::word_t [LANES-1:0] vec_t;

    vmem_pkg::word_t data_mem [DATA_DEPTH*LANES];  // flat, by word address
    vmem_pkg::word_t text_mem [TEXT_DEPTH];

    logic        pending    = 1'b0;
    logic        reset_seen = 1'b0;
    logic [11:0] exp_addr;
    string       exp_name;
    vec_t        expected;

    initial begin
        n_pass = 0;
        n_fail = 0;
    end

    function automatic int lanes_of(logic [2:0] width);
        case (width)
            vmem_pkg::W_1: return 1;
            vmem_pkg::W_2: return 2;
            vmem_pkg::W_4: return 4;
            default:       return LANES;
        endcase
    endfunction

    // data comes back from its start lane, zero above
    function automatic vec_t predict(logic [11:0] a);
        vec_t v;
        int   off;
        v   = '0;
        off = int'(a) % LANES;
        if (a < 12'h800) begin
            for (int i = 0; i < LANES; i++) begin
                if (i + off < LANES) begin
                    v[i] = data_mem[IDX_W'(int'(a) + i)];
                end
            end
        end else if (a < 12'ha00) begin
            v[0] = text_mem[TIDX_W'(a - 12'h800)];
        end else if (a == vmem_pkg::INVL_ADDR) begin
            v = inv_l;
        end else if (a == vmem_pkg::INVU_ADDR) begin
            v = inv_u;
        end
        return v;
    endfunction

    function automatic void apply_write(logic [11:0] a, logic [2:0] width, vec_t d);
        int off;
        off = int'(a) % LANES;
        if (a < 12'h800) begin
            for (int k = 0; k < LANES; k++) begin
                if (k < lanes_of(width) && k + off < LANES) begin  // drop past lane 7
                    data_mem[IDX_W'(int'(a) + k)] = d[k];
                end
            end
        end else if (a < 12'ha00) begin
            text_mem[TIDX_W'(a - 12'h800)] = d[0];
        end
    endfunction

    task automatic check_read(string tname, logic [11:0] a, vec_t exp_v);
        if (rdata === exp_v) begin
            n_pass = n_pass + 1;
            $display("ok       %s (addr %03h)", tname, a);
        end else begin
            n_fail = n_fail + 1;
            $display("MISMATCH rdata %s (addr %03h) expected %h actual %h",
                     tname, a, exp_v, rdata);
        end
    endtask

    // ****************************************
    // compare one cycle after each read
    // ****************************************
    always @(posedge clk) begin
        if (!arst_n) begin
            pending = 1'b0;
        end else begin
            if (pending) begin
                check_read(exp_name, exp_addr, expected);
            end else if (!reset_seen) begin
                check_read("rdata zero after reset", 12'h000, '0);
            end else if (rdata !== '0) begin
                n_fail = n_fail + 1;
                $display("MISMATCH rdata idle cycle expected %h actual %h", vec_t'(0), rdata);
            end
            reset_seen = 1'b1;
            pending    = req.rd;
            if (req.rd) begin
                expected = predict(req.addr);  // before this cycle's write
                exp_addr = req.addr;
                exp_name = name;
            end
            if (req.wr) begin
                apply_write(req.addr, req.width, wdata);
            end
        end
    end

endmodule

// ==== source/vmem_top.sv ====
`timescale 1ns/1ps

module vmem_top #(
    parameter int LANES      = 8,
    parameter int DATA_DEPTH = 256,
    parameter int TEXT_DEPTH = 512
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  vmem_pkg::mem_req_t                req,
    input  vmem_pkg::word_t   [LANES-1:0]     wdata,
    input  vmem_pkg::word_t   [LANES-1:0]     inv_l,  // lower inversion result
    input  vmem_pkg::word_t   [LANES-1:0]     inv_u,  // upper inversion result
    output vmem_pkg::word_t   [LANES-1:0]     rdata
);

    vmem_pkg::bank_req_t [LANES-1:0]  data_req;
    vmem_pkg::bank_req_t              text_req;
    vmem_pkg::rd_tag_t                tag;
    vmem_pkg::word_t     [LANES-1:0]  data_words;
    vmem_pkg::word_t                  text_word;

    // ****************************************
    // decode and lane alignment
    // ****************************************
    mem_controller #(
        .LANES (LANES)
    ) u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .wdata    (wdata),
        .data_req (data_req),
        .text_req (text_req),
        .tag      (tag)
    );

    // ****************************************
    // storage
    // ****************************************
    for (genvar i = 0; i < LANES; i++) begin : g_data_bank
        sram_bank #(
            .DEPTH (DATA_DEPTH)
        ) u_bank (
            .clk   (clk),
            .req   (data_req[i]),
            .rword (data_words[i])
        );
    end

    sram_bank #(
        .DEPTH (TEXT_DEPTH)
    ) u_text_bank (
        .clk   (clk),
        .req   (text_req),
        .rword (text_word)
    );

    // read mux, one cycle after the request
    read_return #(
        .LANES (LANES)
    ) u_ret (
        .tag        (tag),
        .data_words (data_words),
        .text_word  (text_word),
        .inv_l      (inv_l),
        .inv_u      (inv_u),
        .rdata      (rdata)
    );

endmodule

// ==== source/read_return.sv ====
`timescale 1ns/1ps

module read_return #(
    parameter int LANES = 8
) (
    input  vmem_pkg::rd_tag_t              tag,
    input  vmem_pkg::word_t   [LANES-1:0]  data_words,
    input  vmem_pkg::word_t                text_word,
    input  vmem_pkg::word_t   [LANES-1:0]  inv_l,
    input  vmem_pkg::word_t   [LANES-1:0]  inv_u,
    output vmem_pkg::word_t   [LANES-1:0]  rdata
);

    localparam int OFF_W = $clog2(LANES);

    logic [OFF_W-1:0]              offset;
    vmem_pkg::word_t [LANES-1:0]   data_aligned;
    vmem_pkg::word_t [LANES-1:0]   text_vec;

    assign offset = tag.offset[OFF_W-1:0];

    // ****************************************
    // data lanes back to lane 0
    // ****************************************
    always_comb begin
        data_aligned = '0;
        for (int i = 0; i < LANES; i++) begin
            if (i + int'(offset) < LANES) begin
                data_aligned[i] = data_words[i + int'(offset)];
            end
            // upper lanes stay zero
        end
    end

    assign text_vec = (LANES * vmem_pkg::WORD_W)'(text_word); // lane 0, rest zero

    // ****************************************
    // source select, from tag only
    // ****************************************
    always_comb begin
        case (tag.region)
            vmem_pkg::R_DATA: begin
                rdata = data_aligned;
            end
            vmem_pkg::R_TEXT: begin
                rdata = text_vec;
            end
            vmem_pkg::R_INVL_U: begin
                rdata = tag.upper ? inv_u : inv_l;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

// ==== source/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank #(
    parameter int DEPTH = 256
) (
    input  logic                clk,
    input  vmem_pkg::bank_req_t req,
    output vmem_pkg::word_t     rword
);

    localparam int AW = $clog2(DEPTH);

    vmem_pkg::word_t mem [DEPTH];
    logic [AW-1:0]   row;

    assign row = req.row[AW-1:0];

    // ****************************************
    // single port, read first
    // ****************************************
    always_ff @(posedge clk) begin
        if (req.en) begin
            // old contents on a same-cycle write
            rword <= mem[row];
            if (req.we) begin
                mem[row] <= req.wdata;
            end
        end
    end

endmodule

// ==== source/mem_controller.sv ====
`timescale 1ns/1ps

module mem_controller #(
    parameter int LANES = 8
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  vmem_pkg::mem_req_t                  req,
    input  vmem_pkg::word_t     [LANES-1:0]     wdata,
    output vmem_pkg::bank_req_t [LANES-1:0]     data_req,
    output vmem_pkg::bank_req_t                 text_req,
    output vmem_pkg::rd_tag_t                   tag
);

    localparam int OFF_W = $clog2(LANES);

    vmem_pkg::region_e   region;
    logic [OFF_W-1:0]    offset;
    logic [8:0]          data_row;
    logic [LANES-1:0]    base_mask;
    logic [LANES-1:0]    lane_mask;
    vmem_pkg::rd_tag_t   tag_d;

    // ****************************************
    // address decode
    // ****************************************
    always_comb begin
        if ((req.addr & vmem_pkg::DATA_MASK) == vmem_pkg::DATA_BASE) begin
            region = vmem_pkg::R_DATA;
        end else if ((req.addr & vmem_pkg::TEXT_MASK) == vmem_pkg::TEXT_BASE) begin
            region = vmem_pkg::R_TEXT;
        end else if (req.addr == vmem_pkg::INVL_ADDR || req.addr == vmem_pkg::INVU_ADDR) begin
            region = vmem_pkg::R_INVL_U;
        end else begin
            region = vmem_pkg::R_NONE; // unmapped, reads zero
        end
    end

    assign offset   = req.addr[OFF_W-1:0];
    assign data_row = 9'(req.addr[vmem_pkg::ADDR_W-2:0] >> OFF_W); // row above lane offset

    // ****************************************
    // lane mask
    // ****************************************
    always_comb begin
        case (req.width)
            vmem_pkg::W_1: base_mask = LANES'(1'b1);
            vmem_pkg::W_2: base_mask = LANES'(2'b11);
            vmem_pkg::W_4: base_mask = LANES'(4'hf);
            default:       base_mask = '1;
        endcase
    end

    // lanes past the top are dropped
    assign lane_mask = base_mask << offset;

    // ****************************************
    // bank requests
    // ****************************************
    always_comb begin
        logic [OFF_W-1:0] src;
        logic             hit;

        hit = (region == vmem_pkg::R_DATA);
        for (int i = 0; i < LANES; i++) begin
            src = OFF_W'(i) - offset; // rotate lane src into bank i
            data_req[i].en    = hit && (req.rd || (req.wr && lane_mask[i]));
            data_req[i].we    = hit && req.wr && lane_mask[i];
            data_req[i].row   = data_row;
            data_req[i].wdata = wdata[src];
        end
    end

    always_comb begin
        text_req.en    = (region == vmem_pkg::R_TEXT) && (req.rd || req.wr);
        text_req.we    = (region == vmem_pkg::R_TEXT) && req.wr;
        text_req.row   = req.addr[8:0];
        text_req.wdata = wdata[0]; // only lane 0 is stored
    end

    // ****************************************
    // read tag
    // ****************************************
    always_comb begin
        tag_d.region = req.rd ? region : vmem_pkg::R_NONE;
        tag_d.upper  = (req.addr == vmem_pkg::INVU_ADDR);
        tag_d.offset = 3'(offset);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag <= '{region: vmem_pkg::R_NONE, upper: 1'b0, offset: 3'd0};
        end else begin
            tag <= tag_d;
        end
    end

endmodule

// ==== common/vmem_pkg.sv ====
package vmem_pkg;

    // ****************************************
    // widths and words
    // ****************************************
    localparam int WORD_W = 32;
    localparam int ADDR_W = 12;

    typedef logic [WORD_W-1:0] word_t;

    // width codes, any other code is a full vector
    localparam logic [2:0] W_1 = 3'b010;
    localparam logic [2:0] W_2 = 3'b011;
    localparam logic [2:0] W_4 = 3'b100;

    // ****************************************
    // address map
    // ****************************************
    localparam logic [ADDR_W-1:0] DATA_MASK = 12'h800;
    localparam logic [ADDR_W-1:0] DATA_BASE = 12'h000;
    localparam logic [ADDR_W-1:0] TEXT_MASK = 12'he00;
    localparam logic [ADDR_W-1:0] TEXT_BASE = 12'h800; // 800 - 9ff
    localparam logic [ADDR_W-1:0] INVL_ADDR = 12'ha03;
    localparam logic [ADDR_W-1:0] INVU_ADDR = 12'ha04;

    typedef enum logic [1:0] {
        R_NONE,
        R_DATA,
        R_TEXT,
        R_INVL_U  // both inversion results
    } region_e;

    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [2:0]        width;
    } mem_req_t;

    typedef struct packed {
        region_e    region;
        logic       upper;   // inv_u, not inv_l
        logic [2:0] offset;  // start lane of the read
    } rd_tag_t;

    typedef struct packed {
        logic       en;
        logic       we;
        logic [8:0] row;     // data banks only use 8 bits
        word_t      wdata;
    } bank_req_t;

endpackage
